//--- source/fadd_pkg.sv
//////////////////////////////
// add pipe shared definitions
// internal widths, rounding positions and the
// double / single views of one operand word
//////////////////////////////

package fadd_pkg;

	//////////////////////////////
	// internal datapath
	//////////////////////////////

	localparam int FRAC_W  = 64;	// [63] carry room, [62] hidden bit, [0] sticky
	localparam int IEXP_W  = 12;	// one bit above the double exponent, carry never wraps
	localparam int LEAD0_W = 6;	// leading zero count over FRAC_W bits

	// result lsb position inside the internal fraction
	localparam int DBL_LSB = 10;	// 52 fraction bits sit on [61:10]
	localparam int SNG_LSB = 39;	// 23 fraction bits sit on [61:39]

	//////////////////////////////
	// word formats
	//////////////////////////////

	typedef struct packed {
		logic        sign;
		logic [10:0] exp;	// biased 1023
		logic [51:0] frac;
	} fp_dbl_t;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;	// biased 127
		logic [22:0] frac;
		logic [31:0] pad;	// lower word, zero on results
	} fp_sng_t;

	// same 64 bit word, read by op precision
	typedef union packed {
		fp_dbl_t dbl;
		fp_sng_t sng;
	} fp_word_u;

endpackage

//--- source/fadd_lead0.sv
`timescale 1ns/1ps
//////////////////////////////
// leading zero counter
// pairwise tree with all-zero flag
//////////////////////////////

module fadd_lead0 #(
	parameter  int DATA_W = 64,	// power of two
	localparam int CNT_W  = $clog2(DATA_W)
) (
	input  logic [DATA_W-1:0] i_data,
	output logic [CNT_W-1:0]  o_lead0,
	output logic              o_zero	// no bit set
);

	logic             zero_tr [CNT_W+1][DATA_W];	// node covers only zeros
	logic [CNT_W-1:0] cnt_tr  [CNT_W+1][DATA_W];	// zeros from the node msb

	always_comb begin
		for (int l = 0; l <= CNT_W; l++) begin
			for (int n = 0; n < DATA_W; n++) begin
				zero_tr[l][n] = 1'b0;
				cnt_tr[l][n]  = '0;
			end
		end
		for (int n = 0; n < DATA_W; n++)
			zero_tr[0][n] = ~i_data[n];	// leaves are single bits
		// node 2n+1 holds the upper half
		for (int l = 0; l < CNT_W; l++) begin
			for (int n = 0; n < (DATA_W >> (l + 1)); n++) begin
				zero_tr[l+1][n] = zero_tr[l][2*n+1] & zero_tr[l][2*n];
				cnt_tr[l+1][n]  = zero_tr[l][2*n+1] ?
					(cnt_tr[l][2*n] | CNT_W'(1 << l)) :	// upper empty, add its width
					cnt_tr[l][2*n+1];
			end
		end
	end

	assign o_lead0 = cnt_tr[CNT_W][0];
	assign o_zero  = zero_tr[CNT_W][0];

endmodule

//--- source/fadd_unpack.sv
`timescale 1ns/1ps
//////////////////////////////
// add pipe stage 1
// unpack both operands, compare magnitudes
// and swap so the larger one leads
//////////////////////////////

module fadd_unpack (
	input  logic                        rclk,
	input  logic                        i_rst_n,
	input  logic                        i_valid,
	input  logic                        i_sngop,	// single precision op
	input  logic                        i_sub,	// subtract request
	input  fadd_pkg::fp_word_u          i_in1,
	input  fadd_pkg::fp_word_u          i_in2,
	output logic                        o_valid,
	output logic                        o_sngop,
	output logic                        o_sign,	// sign of the larger magnitude
	output logic                        o_eff_sub,	// effective subtract
	output logic [fadd_pkg::IEXP_W-1:0] o_exp,	// larger exponent
	output logic [fadd_pkg::IEXP_W-1:0] o_exp_diff,	// right shift for the smaller
	output logic [fadd_pkg::FRAC_W-1:0] o_frac_big,
	output logic [fadd_pkg::FRAC_W-1:0] o_frac_small
);
	import fadd_pkg::*;

	logic [IEXP_W-1:0] exp1;
	logic [IEXP_W-1:0] exp2;
	logic [FRAC_W-1:0] frac1;
	logic [FRAC_W-1:0] frac2;
	logic              sign1;
	logic              sign2;	// already flipped for subtract
	logic              in2_gt;	// |in2| > |in1|

	// zero exponent field reads as 1, no hidden bit
	function automatic logic [IEXP_W-1:0] unpack_exp(fp_word_u w, logic sng);
		logic [IEXP_W-1:0] e;
		e = sng ? IEXP_W'(w.sng.exp) : IEXP_W'(w.dbl.exp);
		return (e == '0) ? IEXP_W'(1) : e;
	endfunction

	// fraction with the hidden bit on [62]
	function automatic logic [FRAC_W-1:0] unpack_frac(fp_word_u w, logic sng);
		logic hid;
		hid = sng ? (w.sng.exp != '0) : (w.dbl.exp != '0);
		if (sng)
			return {1'b0, hid, w.sng.frac, {SNG_LSB{1'b0}}};
		return {1'b0, hid, w.dbl.frac, {DBL_LSB{1'b0}}};
	endfunction

	assign exp1  = unpack_exp(i_in1, i_sngop);
	assign exp2  = unpack_exp(i_in2, i_sngop);
	assign frac1 = unpack_frac(i_in1, i_sngop);
	assign frac2 = unpack_frac(i_in2, i_sngop);

	assign sign1 = i_in1.dbl.sign;	// bit 63 in both views
	assign sign2 = i_in2.dbl.sign ^ i_sub;

	// exponent first, fraction breaks the tie
	assign in2_gt = (exp2 > exp1) || ((exp2 == exp1) && (frac2 > frac1));

	//////////////////////////////
	// stage 1 registers
	//////////////////////////////

	always_ff @(posedge rclk) begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge rclk) begin
		if (i_valid) begin
			o_sngop      <= i_sngop;
			o_sign       <= in2_gt ? sign2 : sign1;
			o_eff_sub    <= sign1 ^ sign2;
			o_exp        <= in2_gt ? exp2 : exp1;
			o_exp_diff   <= in2_gt ? (exp2 - exp1) : (exp1 - exp2);	// never negative
			o_frac_big   <= in2_gt ? frac2 : frac1;
			o_frac_small <= in2_gt ? frac1 : frac2;
		end
	end

endmodule

//--- source/fadd_align_shr.sv
`timescale 1ns/1ps
//////////////////////////////
// add pipe stage 2
// right shift of the smaller fraction,
// shifted out bits collect into sticky
//////////////////////////////

module fadd_align_shr (
	input  logic                        rclk,
	input  logic                        i_rst_n,
	input  logic                        i_valid,
	input  logic                        i_sngop,
	input  logic                        i_sign,
	input  logic                        i_eff_sub,
	input  logic [fadd_pkg::IEXP_W-1:0] i_exp,
	input  logic [fadd_pkg::IEXP_W-1:0] i_exp_diff,
	input  logic [fadd_pkg::FRAC_W-1:0] i_frac_big,
	input  logic [fadd_pkg::FRAC_W-1:0] i_frac_small,
	output logic                        o_valid,
	output logic                        o_sngop,
	output logic                        o_sign,
	output logic                        o_eff_sub,
	output logic [fadd_pkg::IEXP_W-1:0] o_exp,
	output logic [fadd_pkg::FRAC_W-1:0] o_frac_big,
	output logic [fadd_pkg::FRAC_W-1:0] o_frac_small	// aligned, sticky on [0]
);
	import fadd_pkg::*;

	logic [FRAC_W-1:0] shr_v;	// running shift value
	logic              shr_st;	// running sticky
	logic              shr_max;	// diff of FRAC_W or more
	logic [FRAC_W-1:0] frac_aligned;

	assign shr_max = |i_exp_diff[IEXP_W-1:LEAD0_W];

	// log shifter, one level per count bit
	always_comb begin
		shr_v  = i_frac_small;
		shr_st = 1'b0;
		for (int k = 0; k < LEAD0_W; k++) begin
			if (i_exp_diff[k]) begin
				shr_st = shr_st | (|(shr_v & ((FRAC_W'(1) << (1 << k)) - FRAC_W'(1))));
				shr_v  = shr_v >> (1 << k);
			end
		end
		if (shr_max) begin	// whole fraction falls off
			shr_v  = '0;
			shr_st = |i_frac_small;
		end
	end

	assign frac_aligned = {shr_v[FRAC_W-1:1], shr_v[0] | shr_st};

	//////////////////////////////
	// stage 2 registers
	//////////////////////////////

	always_ff @(posedge rclk) begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge rclk) begin
		if (i_valid) begin
			o_sngop      <= i_sngop;
			o_sign       <= i_sign;
			o_eff_sub    <= i_eff_sub;
			o_exp        <= i_exp;
			o_frac_big   <= i_frac_big;	// larger one needs no shift
			o_frac_small <= frac_aligned;
		end
	end

endmodule

//--- source/fadd_frac_add.sv
`timescale 1ns/1ps
//////////////////////////////
// add pipe stage 3
// main adder, leading zeros and denorm limit
// on the normalize shift count
//////////////////////////////

module fadd_frac_add #(
	parameter int DATA_W = fadd_pkg::FRAC_W	// width handed to the counter
) (
	input  logic                         rclk,
	input  logic                         i_rst_n,
	input  logic                         i_valid,
	input  logic                         i_sngop,
	input  logic                         i_sign,
	input  logic                         i_eff_sub,
	input  logic [fadd_pkg::IEXP_W-1:0]  i_exp,
	input  logic [fadd_pkg::FRAC_W-1:0]  i_frac_big,
	input  logic [fadd_pkg::FRAC_W-1:0]  i_frac_small,
	output logic                         o_valid,
	output logic                         o_sngop,
	output logic                         o_sign,
	output logic                         o_zero,	// exact zero sum
	output logic [fadd_pkg::IEXP_W-1:0]  o_exp,	// exponent after normalize
	output logic [fadd_pkg::FRAC_W-1:0]  o_sum,
	output logic [fadd_pkg::LEAD0_W-1:0] o_shl_cnt
);
	import fadd_pkg::*;

	logic [FRAC_W-1:0]  add_in2;
	logic [FRAC_W-1:0]  sum;
	logic [LEAD0_W-1:0] lead0;
	logic               sum_zero;
	logic               carry;	// sum spilled into [63]
	logic [LEAD0_W-1:0] lz_norm;	// zeros above the hidden bit
	logic [IEXP_W-1:0]  exp_lim;	// largest shift keeping exp >= 1
	logic               dnrm_lim;
	logic [LEAD0_W-1:0] shl_cnt;
	logic [IEXP_W-1:0]  exp_adj;

	//////////////////////////////
	// main adder
	//////////////////////////////

	// subtract as big + ~small + 1, big >= small so no sign out
	assign add_in2 = i_eff_sub ? ~i_frac_small : i_frac_small;
	assign sum     = i_frac_big + add_in2 + FRAC_W'(i_eff_sub);
	assign carry   = sum[FRAC_W-1];

	fadd_lead0 #(
		.DATA_W (DATA_W)
	) u_lead0 (
		.i_data  (sum),
		.o_lead0 (lead0),
		.o_zero  (sum_zero)
	);

	//////////////////////////////
	// shift count and exponent
	//////////////////////////////

	assign lz_norm  = lead0 - LEAD0_W'(1);	// bit 63 is headroom
	assign exp_lim  = i_exp - IEXP_W'(1);	// exponent decode of the denorm edge
	assign dnrm_lim = IEXP_W'(lz_norm) > exp_lim;

	assign shl_cnt = carry ? '0 :
		dnrm_lim ? exp_lim[LEAD0_W-1:0] : lz_norm;	// clip into a denormal

	assign exp_adj = carry ? (i_exp + IEXP_W'(1)) : (i_exp - IEXP_W'(shl_cnt));

	always_ff @(posedge rclk) begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	always_ff @(posedge rclk) begin
		if (i_valid) begin
			o_sngop   <= i_sngop;
			o_sign    <= i_sign & ~sum_zero;	// exact zero is +0
			o_zero    <= sum_zero;
			o_exp     <= exp_adj;
			o_sum     <= sum;
			o_shl_cnt <= shl_cnt;	// ignored when carry asks for shr 1
		end
	end

endmodule

//--- source/fadd_norm_round.sv
`timescale 1ns/1ps
//////////////////////////////
// add pipe stage 4
// normalize shift, round to nearest even
// and pack the result word
//////////////////////////////

module fadd_norm_round (
	input  logic                         rclk,
	input  logic                         i_rst_n,
	input  logic                         i_valid,
	input  logic                         i_sngop,
	input  logic                         i_sign,
	input  logic                         i_zero,
	input  logic [fadd_pkg::IEXP_W-1:0]  i_exp,
	input  logic [fadd_pkg::FRAC_W-1:0]  i_sum,
	input  logic [fadd_pkg::LEAD0_W-1:0] i_shl_cnt,
	output logic                         o_valid,
	output logic                         o_inexact,
	output logic                         o_denorm,	// exponent field is zero
	output fadd_pkg::fp_word_u           o_result
);
	import fadd_pkg::*;

	localparam int MANT_W = FRAC_W - 1 - DBL_LSB;	// 53, hidden bit included
	localparam int RND_W  = MANT_W + 1;	// plus rounding carry

	logic [FRAC_W-1:0]   shl_frac;
	logic                lsb;
	logic                grd;
	logic                rnd;
	logic                stk;
	logic                rnd_up;
	logic [RND_W-1:0]    rnd_inc;
	logic [RND_W-1:0]    rnd_sum;
	logic                rnd_cout;	// carry out of the hidden bit
	logic                rnd_hid;
	logic [MANT_W-2:0]   res_frac;
	logic [IEXP_W-1:0]   res_exp;
	fp_word_u            res_word;

	//////////////////////////////
	// normalize
	//////////////////////////////

	// adder carry shifts right once, bit 0 kept as sticky
	assign shl_frac = i_sum[FRAC_W-1] ?
		{1'b0, i_sum[FRAC_W-1:2], i_sum[1] | i_sum[0]} :
		(i_sum << i_shl_cnt);

	//////////////////////////////
	// round
	//////////////////////////////

	assign lsb = i_sngop ? shl_frac[SNG_LSB]   : shl_frac[DBL_LSB];
	assign grd = i_sngop ? shl_frac[SNG_LSB-1] : shl_frac[DBL_LSB-1];
	assign rnd = i_sngop ? shl_frac[SNG_LSB-2] : shl_frac[DBL_LSB-2];
	assign stk = i_sngop ? |shl_frac[SNG_LSB-3:0] : |shl_frac[DBL_LSB-3:0];

	assign rnd_up = grd & (lsb | rnd | stk);	// ties go to even

	// single increments at its own lsb, bits under it are dropped
	assign rnd_inc  = RND_W'(rnd_up) << (i_sngop ? (SNG_LSB - DBL_LSB) : 0);
	assign rnd_sum  = {1'b0, shl_frac[FRAC_W-2:DBL_LSB]} + rnd_inc;
	assign rnd_cout = rnd_sum[RND_W-1];
	assign rnd_hid  = rnd_sum[RND_W-2];

	assign res_frac = rnd_cout ? rnd_sum[RND_W-2:1] : rnd_sum[RND_W-3:0];

	// no hidden bit left means a denormal field, a denormal that
	// rounds into the hidden bit already carries exponent 1
	assign res_exp = ((rnd_cout | rnd_hid) && !i_zero) ?
		(i_exp + IEXP_W'(rnd_cout)) : '0;

	//////////////////////////////
	// pack
	//////////////////////////////

	always_comb begin
		if (i_sngop)
			res_word.sng = {i_sign, res_exp[7:0], res_frac[MANT_W-2 -: 23], 32'b0};
		else
			res_word.dbl = {i_sign, res_exp[10:0], res_frac};
	end

	always_ff @(posedge rclk) begin
		if (!i_rst_n) begin
			o_valid   <= 1'b0;
			o_inexact <= 1'b0;
			o_denorm  <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				o_inexact <= grd | rnd | stk;	// any dropped bit set
				o_denorm  <= (res_exp == '0);
			end
		end
	end

	always_ff @(posedge rclk) begin
		if (i_valid)
			o_result <= res_word;
	end

endmodule

//--- source/fadd_top.sv
`timescale 1ns/1ps
//////////////////////////////
// floating point add / subtract
// four stage pipe, one op per cycle
//////////////////////////////

module fadd_top (
	input  logic               rclk,
	input  logic               i_rst_n,
	input  logic               i_valid,
	input  logic               i_sngop,
	input  logic               i_sub,
	input  fadd_pkg::fp_word_u i_in1,
	input  fadd_pkg::fp_word_u i_in2,
	output logic               o_valid,
	output logic               o_inexact,
	output logic               o_denorm,
	output fadd_pkg::fp_word_u o_result
);
	import fadd_pkg::*;

	// stage 1 to 2
	logic               s1_valid;
	logic               s1_sngop;
	logic               s1_sign;
	logic               s1_eff_sub;
	logic [IEXP_W-1:0]  s1_exp;
	logic [IEXP_W-1:0]  s1_exp_diff;
	logic [FRAC_W-1:0]  s1_frac_big;
	logic [FRAC_W-1:0]  s1_frac_small;

	// stage 2 to 3
	logic               s2_valid;
	logic               s2_sngop;
	logic               s2_sign;
	logic               s2_eff_sub;
	logic [IEXP_W-1:0]  s2_exp;
	logic [FRAC_W-1:0]  s2_frac_big;
	logic [FRAC_W-1:0]  s2_frac_small;

	// stage 3 to 4
	logic               s3_valid;
	logic               s3_sngop;
	logic               s3_sign;
	logic               s3_zero;
	logic [IEXP_W-1:0]  s3_exp;
	logic [FRAC_W-1:0]  s3_sum;
	logic [LEAD0_W-1:0] s3_shl_cnt;

	fadd_unpack u_unpack (
		.rclk         (rclk),
		.i_rst_n      (i_rst_n),
		.i_valid      (i_valid),
		.i_sngop      (i_sngop),
		.i_sub        (i_sub),
		.i_in1        (i_in1),
		.i_in2        (i_in2),
		.o_valid      (s1_valid),
		.o_sngop      (s1_sngop),
		.o_sign       (s1_sign),
		.o_eff_sub    (s1_eff_sub),
		.o_exp        (s1_exp),
		.o_exp_diff   (s1_exp_diff),
		.o_frac_big   (s1_frac_big),
		.o_frac_small (s1_frac_small)
	);

	fadd_align_shr u_align_shr (
		.rclk         (rclk),
		.i_rst_n      (i_rst_n),
		.i_valid      (s1_valid),
		.i_sngop      (s1_sngop),
		.i_sign       (s1_sign),
		.i_eff_sub    (s1_eff_sub),
		.i_exp        (s1_exp),
		.i_exp_diff   (s1_exp_diff),
		.i_frac_big   (s1_frac_big),
		.i_frac_small (s1_frac_small),
		.o_valid      (s2_valid),
		.o_sngop      (s2_sngop),
		.o_sign       (s2_sign),
		.o_eff_sub    (s2_eff_sub),
		.o_exp        (s2_exp),
		.o_frac_big   (s2_frac_big),
		.o_frac_small (s2_frac_small)
	);

	fadd_frac_add #(
		.DATA_W (FRAC_W)
	) u_frac_add (
		.rclk         (rclk),
		.i_rst_n      (i_rst_n),
		.i_valid      (s2_valid),
		.i_sngop      (s2_sngop),
		.i_sign       (s2_sign),
		.i_eff_sub    (s2_eff_sub),
		.i_exp        (s2_exp),
		.i_frac_big   (s2_frac_big),
		.i_frac_small (s2_frac_small),
		.o_valid      (s3_valid),
		.o_sngop      (s3_sngop),
		.o_sign       (s3_sign),
		.o_zero       (s3_zero),
		.o_exp        (s3_exp),
		.o_sum        (s3_sum),
		.o_shl_cnt    (s3_shl_cnt)
	);

	fadd_norm_round u_norm_round (
		.rclk      (rclk),
		.i_rst_n   (i_rst_n),
		.i_valid   (s3_valid),
		.i_sngop   (s3_sngop),
		.i_sign    (s3_sign),
		.i_zero    (s3_zero),
		.i_exp     (s3_exp),
		.i_sum     (s3_sum),
		.i_shl_cnt (s3_shl_cnt),
		.o_valid   (o_valid),
		.o_inexact (o_inexact),
		.o_denorm  (o_denorm),
		.o_result  (o_result)
	);

endmodule

//--- verif/fadd_clk_gen.sv
`timescale 1ns/1ps
//////////////////////////////
// testbench clock and reset
//////////////////////////////

module fadd_clk_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RST_CYC   = 8	// edges with reset held low
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYC) @(posedge o_clk);
		o_rst_n <= 1'b1;	// released on an edge, like the stimulus
	end

endmodule

//--- verif/fadd_ref.svh
//////////////////////////////
// add pipe testbench helpers
// reference add model, lfsr step and value check
//////////////////////////////

`ifndef FADD_REF_SVH
`define FADD_REF_SVH

// galois lfsr in right shift form of x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// exact sum on wide integers then rounded to nearest even
function automatic void ref_add(
	input  fp_word_u    a,
	input  fp_word_u    b,
	input  logic        sng,
	input  logic        sub,
	output logic [63:0] res,
	output logic        inx,
	output logic        dnm
);
	int           fb;	// stored fraction bits
	int           ea;
	int           eb;
	int           eh;	// exponent of the larger operand
	int           ef;	// final exponent
	int           ex;	// exponent field
	int           p;	// msb of the raw sum
	int           l;	// result lsb inside the raw sum
	logic         sa;
	logic         sb;
	logic         sr;
	logic         stk;
	logic         up;
	logic [127:0] ma;
	logic [127:0] mb;
	logic [127:0] mh;
	logic [127:0] ml;
	logic [127:0] r;
	logic [127:0] rem;
	logic [127:0] mant;

	sa = a.dbl.sign;
	sb = b.dbl.sign ^ sub;	// subtract flips operand 2
	fb = sng ? 23 : 52;
	ea = sng ? int'(a.sng.exp) : int'(a.dbl.exp);
	eb = sng ? int'(b.sng.exp) : int'(b.dbl.exp);
	ma = sng ? 128'(a.sng.frac) : 128'(a.dbl.frac);
	mb = sng ? 128'(b.sng.frac) : 128'(b.dbl.frac);
	// hidden bit on normals and a zero field counts as exponent 1
	if (ea != 0)
		ma = ma | (128'(1) << fb);
	else
		ea = 1;
	if (eb != 0)
		mb = mb | (128'(1) << fb);
	else
		eb = 1;

	//////////////////////////////
	// align and add
	//////////////////////////////

	if (eb > ea || (eb == ea && mb > ma)) begin
		eh = eb;
		sr = sb;
		mh = mb << 64;	// 64 spare bits under the lsb
		ml = ma << 64;
		l  = eb - ea;
	end else begin
		eh = ea;
		sr = sa;
		mh = ma << 64;
		ml = mb << 64;
		l  = ea - eb;
	end
	if (l >= 128) begin
		ml = 128'(ml != '0);	// only sticky left
	end else begin
		stk = |(ml & ((128'(1) << l) - 128'(1)));
		ml  = (ml >> l) | 128'(stk);
	end
	r = (sa ^ sb) ? (mh - ml) : (mh + ml);

	if (r == '0) begin
		res = '0;	// exact zero comes out +0
		inx = 1'b0;
		dnm = 1'b1;
	end else begin
		p = 127;
		while (!r[p])
			p--;
		ef = eh + p - (fb + 64);	// msb taken as hidden bit
		if (ef < 1)
			ef = 1;	// stuck in the denormal range
		l    = 64 + ef - eh;
		mant = r >> l;
		rem  = r & ((128'(1) << l) - 128'(1));
		up   = (rem > (128'(1) << (l - 1))) ||
			(rem == (128'(1) << (l - 1)) && mant[0]);	// tie goes to even
		mant = mant + 128'(up);
		if (mant[fb+1]) begin	// rounded past the hidden bit
			mant = mant >> 1;
			ef++;
		end
		ex  = mant[fb] ? ef : 0;
		inx = (rem != '0);
		dnm = (ex == 0);
		if (sng)
			res = {sr, 8'(ex), mant[22:0], 32'b0};
		else
			res = {sr, 11'(ex), mant[51:0]};
	end
endfunction

// compare one value with its expected value
task automatic check_val(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
	if (exp_v !== act_v) begin
		$display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
		$display("Simulation finished: FAIL");
		$fatal(1, "value mismatch in %s", name);
	end
endtask

`endif

//--- verif/tb_fadd.sv
`timescale 1ns/1ps
//////////////////////////////
// add pipe testbench
// directed and random ops against a reference model
//////////////////////////////

module tb_fadd;
	import fadd_pkg::*;

	localparam int CLK_NS    = 8;
	localparam int LATENCY   = 4;
	localparam int N_DIRECT  = 16;
	localparam int N_GRP     = 20;	// per random double group
	localparam int N_STREAM  = 200;
	localparam int NUM_OPS   = N_DIRECT + 2 * N_GRP + N_STREAM;
	localparam int WDOG_NS   = (NUM_OPS + LATENCY + 20) * CLK_NS;
	localparam int D_EXP_LIM = 2045;	// two below the all ones field so sums stay finite
	localparam int S_EXP_LIM = 253;

	logic     clk;
	logic     rst_n;
	logic     i_valid;
	logic     i_sngop;
	logic     i_sub;
	fp_word_u i_in1;
	fp_word_u i_in2;
	logic     o_valid;
	logic     o_inexact;
	logic     o_denorm;
	fp_word_u o_result;

	// expected values with one entry per op in flight
	string       name_q [$];
	logic [63:0] res_q  [$];
	logic        inx_q  [$];
	logic        dnm_q  [$];
	int          due_q  [$];	// cycle the result must show up

	int          cyc    = 0;
	logic [31:0] lfsr_q = 32'h89c;

	`include "fadd_ref.svh"

	fadd_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYC(8)) u_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	fadd_top UUT (
		.rclk      (clk),
		.i_rst_n   (rst_n),
		.i_valid   (i_valid),
		.i_sngop   (i_sngop),
		.i_sub     (i_sub),
		.i_in1     (i_in1),
		.i_in2     (i_in2),
		.o_valid   (o_valid),
		.o_inexact (o_inexact),
		.o_denorm  (o_denorm),
		.o_result  (o_result)
	);

	// one lfsr step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = {v[62:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic int pick_exp(input logic sng);
		if (rand_bits(3) == 0)
			return 0;	// denormal now and then
		if (sng)
			return int'(rand_bits(8) % 64'(S_EXP_LIM));
		return int'(rand_bits(11) % 64'(D_EXP_LIM));
	endfunction

	// same exponent or one above for cancellation
	function automatic int close_exp(input logic sng, input int e);
		int e2;
		e2 = e + int'(rand_bits(1));
		if (e2 >= (sng ? S_EXP_LIM : D_EXP_LIM))
			e2 = e;
		return e2;
	endfunction

	function automatic logic [63:0] make_op(input logic sng, input int e);
		fp_word_u w;
		w = rand_bits(64);	// single ops keep a random low word
		if (sng)
			w.sng.exp = 8'(e);
		else
			w.dbl.exp = 11'(e);
		return w;
	endfunction

	task automatic issue_op(input string name, input logic sng, input logic sub,
			input logic [63:0] a, input logic [63:0] b);
		logic [63:0] res;
		logic        inx;
		logic        dnm;
		ref_add(a, b, sng, sub, res, inx, dnm);
		@(posedge clk);
		i_valid <= 1'b1;
		i_sngop <= sng;
		i_sub   <= sub;
		i_in1   <= a;
		i_in2   <= b;
		name_q.push_back(name);
		res_q.push_back(res);
		inx_q.push_back(inx);
		dnm_q.push_back(dnm);
		due_q.push_back(cyc + LATENCY + 1);	// output register seen one edge later
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		i_valid <= 1'b0;
	endtask

	always @(posedge clk)
		cyc <= cyc + 1;

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		logic [63:0] a;
		logic [63:0] b;
		logic        s;
		int          e;
		i_valid = 1'b0;
		i_sngop = 1'b0;
		i_sub   = 1'b0;
		i_in1   = '0;
		i_in2   = '0;
		wait (rst_n === 1'b1);
		repeat (2) @(posedge clk);	// o_valid must stay low while idle

		// double adds with one adder carry
		issue_op("d_add_carry", 1'b0, 1'b0, 64'h3FF8_0000_0000_0000, 64'h3FF8_0000_0000_0000);
		issue_op("d_add_inexact", 1'b0, 1'b0, 64'h3FF0_0000_0000_0000, 64'h3C30_0000_0000_0000);
		issue_op("d_add_tie_even", 1'b0, 1'b0, 64'h3FF0_0000_0000_0000, 64'h3CA0_0000_0000_0000);
		// cancellation and zero
		issue_op("d_sub_cancel", 1'b0, 1'b1, 64'h3FF0_0000_0000_0001, 64'h3FF0_0000_0000_0000);
		issue_op("d_sub_near", 1'b0, 1'b1, 64'h3FF0_0000_0000_0000, 64'h3FEF_FFFF_FFFF_FFFF);
		issue_op("d_sub_self", 1'b0, 1'b1, 64'h4008_0000_0000_0000, 64'h4008_0000_0000_0000);
		issue_op("d_add_negated", 1'b0, 1'b0, 64'h4008_0000_0000_0000, 64'hC008_0000_0000_0000);
		// single ops with junk in the low word
		issue_op("s_add", 1'b1, 1'b0, 64'h3F80_0000_0000_0000, 64'h3F80_0000_0000_0000);
		issue_op("s_tie_even", 1'b1, 1'b0, 64'h3F80_0000_1234_5678, 64'h3380_0000_0000_0000);
		issue_op("s_tie_odd", 1'b1, 1'b0, 64'h3F80_0001_0000_0000, 64'h3380_0000_FFFF_FFFF);
		issue_op("s_sub", 1'b1, 1'b1, 64'h4040_0000_A5A5_5A5A, 64'h3F80_0000_0000_0001);
		// denormals
		issue_op("d_dnrm_add", 1'b0, 1'b0, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0001);
		issue_op("d_dnrm_to_norm", 1'b0, 1'b0, 64'h000F_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0001);
		issue_op("d_norm_to_dnrm", 1'b0, 1'b1, 64'h0010_0000_0000_0000, 64'h0000_0000_0000_0001);
		issue_op("d_dnrm_inexact", 1'b0, 1'b0, 64'h3FF0_0000_0000_0000, 64'h8000_0000_0000_0001);
		issue_op("s_dnrm_to_norm", 1'b1, 1'b0, 64'h007F_FFFF_0000_0000, 64'h0000_0001_0000_0000);

		for (int i = 0; i < N_GRP; i++) begin	// same signs and any exponents
			a     = make_op(1'b0, pick_exp(1'b0));
			b     = make_op(1'b0, pick_exp(1'b0));
			b[63] = a[63];
			issue_op("d_add_rand", 1'b0, 1'b0, a, b);
		end
		for (int i = 0; i < N_GRP; i++) begin	// close operands under subtract
			e = pick_exp(1'b0);
			a = make_op(1'b0, e);
			b = rand_bits(1) ? (a ^ rand_bits(8)) : make_op(1'b0, close_exp(1'b0, e));
			b[63] = a[63];
			issue_op("d_sub_rand", 1'b0, 1'b1, a, b);
		end
		for (int i = 0; i < N_STREAM; i++) begin	// mixed stream
			s = 1'(rand_bits(1));
			e = pick_exp(s);
			a = make_op(s, e);
			b = rand_bits(1) ? make_op(s, close_exp(s, e)) : make_op(s, pick_exp(s));
			issue_op($sformatf("stream_%0d", i), s, 1'(rand_bits(1)), a, b);
		end
		idle_cycle();
		repeat (LATENCY + 3) @(posedge clk);	// drain the pipe

		if (res_q.size() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("%0d results never came out", res_q.size());
			$display("Simulation finished: FAIL");
			$fatal(1, "missing results");
		end
	end

	//////////////////////////////
	// comparator
	//////////////////////////////

	always @(posedge clk) begin
		if (rst_n && o_valid === 1'b1) begin
			if (res_q.size() == 0) begin
				$display("result came out with no operation in flight");
				$display("Simulation finished: FAIL");
				$fatal(1, "unexpected result");
			end else begin
				check_val({name_q[0], " latency"}, 64'(due_q[0]), 64'(cyc));
				check_val({name_q[0], " result"}, res_q[0], o_result);
				check_val({name_q[0], " inexact"}, 64'(inx_q[0]), 64'(o_inexact));
				check_val({name_q[0], " denorm"}, 64'(dnm_q[0]), 64'(o_denorm));
				void'(name_q.pop_front());
				void'(res_q.pop_front());
				void'(inx_q.pop_front());
				void'(dnm_q.pop_front());
				void'(due_q.pop_front());
			end
		end else if (rst_n) begin
			check_val("o_valid idle", 64'(0), 64'(o_valid));	// catches x as well
		end
	end

	// ends the run when results stop coming
	initial begin
		#(WDOG_NS);
		$display("watchdog timeout, results stopped arriving");
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

endmodule

//--- all.f
+incdir+verif
source/fadd_pkg.sv
source/fadd_lead0.sv
source/fadd_unpack.sv
source/fadd_align_shr.sv
source/fadd_frac_add.sv
source/fadd_norm_round.sv
source/fadd_top.sv
verif/fadd_clk_gen.sv
verif/tb_fadd.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_fadd
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
